// ==== rtl/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    typedef logic [31:0] wordT;
    // Bit 5 selects the floating-point bank
    typedef logic [5:0]  regAddrT;
    typedef logic [4:0]  regFieldT;
    typedef logic [5:0]  opcodeT;
    typedef logic [5:0]  funcT;

    // Instruction formats from bits 31..30
    localparam logic [1:0] FormatRegister = 2'b00;
    localparam logic [1:0] FormatJump     = 2'b01;
    localparam logic       FormatImmediateBit = 1'b1;

    // Category held in bits 5..0 of a register-format word
    localparam funcT CategoryFloat = 6'd2;

    // Opcodes that need their own handling
    localparam opcodeT OpLoad   = 6'b111000;
    localparam opcodeT OpLoadS  = 6'b111001;
    localparam opcodeT OpStore  = 6'b111010;
    localparam opcodeT OpStoreS = 6'b111011;
    localparam opcodeT OpJreg   = 6'b111100;
    localparam opcodeT OpBez    = 6'b111101;
    localparam opcodeT OpBnez   = 6'b111110;
    localparam opcodeT OpJal    = 6'b111111;
    localparam opcodeT OpJmp    = 6'b010000;
    localparam opcodeT OpAddis  = 6'b110000;

    // Integer to float conversions write the float bank
    localparam funcT FuncIToF  = 6'b001110;
    localparam funcT FuncUIToF = 6'b001111;

endpackage

`default_nettype wire

// ==== rtl/decodeIf.sv ====
`timescale 1ns/10ps
`default_nettype none

interface decodeIf;

    cpuPkg::regAddrT source1;
    cpuPkg::regAddrT source2;
    cpuPkg::regAddrT destination;
    cpuPkg::wordT    immediate;
    logic            useImmediate;
    cpuPkg::funcT    functionCode;

    // Control flags
    logic isLoad;
    logic isStore;
    logic isJal;
    logic relativeJump;
    logic absoluteJump;
    logic unconditionalJump;
    logic conditionalJump;
    logic branchOnZero;

    logic decodedValid;

    modport decoder (
        output source1, source2, destination, immediate, useImmediate, functionCode,
        output isLoad, isStore, isJal, relativeJump, absoluteJump,
        output unconditionalJump, conditionalJump, branchOnZero,
        output decodedValid
    );

    modport operands (
        input source1, source2, destination, immediate, useImmediate, functionCode,
        input isLoad, isStore, isJal, relativeJump, absoluteJump,
        input unconditionalJump, conditionalJump, branchOnZero,
        input decodedValid
    );

endinterface

`default_nettype wire

// ==== rtl/instructionDecoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module instructionDecoder (
    input  logic         Clock,
    input  logic         arstN,
    input  cpuPkg::wordT instruction,
    input  logic         decodeStrobe,
    decodeIf.decoder     decoded
);

    cpuPkg::wordT     currentInstruction;
    logic             validReg;

    cpuPkg::opcodeT   opcode;
    logic [1:0]       format;
    cpuPkg::funcT     lowBits;
    cpuPkg::regFieldT fieldDest;
    cpuPkg::regFieldT fieldSrc1;
    cpuPkg::regFieldT fieldSrc2;
    logic [15:0]      shortImmediate;
    logic [25:0]      longImmediate;

    logic isRegisterFormat;
    logic isJumpFormat;
    logic isImmediateFormat;
    logic isFloatRegister;
    logic floatDestination;
    logic noFunction;

    // Instruction register and valid flag
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            currentInstruction <= '0;
            validReg           <= 1'b0;
        end else begin
            validReg <= decodeStrobe;
            if (decodeStrobe) begin
                currentInstruction <= instruction;
            end
        end
    end

    assign opcode         = currentInstruction[31:26];
    assign format         = currentInstruction[31:30];
    assign lowBits        = currentInstruction[5:0];
    assign fieldDest      = currentInstruction[25:21];
    assign fieldSrc1      = currentInstruction[20:16];
    assign fieldSrc2      = currentInstruction[15:11];
    assign shortImmediate = currentInstruction[15:0];
    assign longImmediate  = currentInstruction[25:0];

    assign isRegisterFormat  = (format == cpuPkg::FormatRegister);
    assign isJumpFormat      = (format == cpuPkg::FormatJump);
    assign isImmediateFormat = (format[1] == cpuPkg::FormatImmediateBit);
    assign isFloatRegister   = isRegisterFormat && (lowBits == cpuPkg::CategoryFloat);

    // Float loads, stores, float ops and conversions target the float bank
    assign floatDestination = (opcode == cpuPkg::OpLoadS) || (opcode == cpuPkg::OpStoreS)
        || (isFloatRegister && (lowBits[3:0] < 4'd8))
        || (isRegisterFormat
            && ((lowBits == cpuPkg::FuncIToF) || (lowBits == cpuPkg::FuncUIToF)));

    assign noFunction = (opcode == cpuPkg::OpAddis) || isJumpFormat
        || ((opcode >= cpuPkg::OpLoad) && (opcode <= cpuPkg::OpJal));

    assign decoded.source1 = {isFloatRegister, fieldSrc1};

    always_comb begin
        if (opcode == cpuPkg::OpStore) begin
            decoded.source2 = {1'b0, fieldDest};
        end else if (opcode == cpuPkg::OpStoreS) begin
            decoded.source2 = {1'b1, fieldDest};
        end else begin
            decoded.source2 = {isFloatRegister, fieldSrc2};
        end
    end

    always_comb begin
        if (floatDestination) begin
            decoded.destination = {1'b1, fieldDest};
        end else if (isRegisterFormat || isImmediateFormat) begin
            decoded.destination = {1'b0, fieldDest};
        end else begin
            decoded.destination = '0;
        end
    end

    always_comb begin
        if (isJumpFormat) begin
            decoded.immediate = {{6{longImmediate[25]}}, longImmediate};
        end else if (opcode == cpuPkg::OpAddis) begin
            decoded.immediate = {shortImmediate, 16'b0};
        end else if (isImmediateFormat) begin
            decoded.immediate = {{16{shortImmediate[15]}}, shortImmediate};
        end else begin
            decoded.immediate = '0;
        end
    end

    assign decoded.useImmediate = isJumpFormat || isImmediateFormat;

    always_comb begin
        if (isRegisterFormat) begin
            decoded.functionCode = lowBits;
        end else if (noFunction) begin
            decoded.functionCode = '0;
        end else begin
            decoded.functionCode = {1'b0, currentInstruction[30:26]};
        end
    end

    assign decoded.isLoad       = (opcode == cpuPkg::OpLoad) || (opcode == cpuPkg::OpLoadS);
    assign decoded.isStore      = (opcode == cpuPkg::OpStore) || (opcode == cpuPkg::OpStoreS);
    assign decoded.isJal        = (opcode == cpuPkg::OpJal);
    assign decoded.relativeJump = (opcode == cpuPkg::OpJal) || (opcode == cpuPkg::OpJmp)
        || (opcode == cpuPkg::OpBez) || (opcode == cpuPkg::OpBnez);
    assign decoded.absoluteJump = (opcode == cpuPkg::OpJreg);
    assign decoded.unconditionalJump = (opcode == cpuPkg::OpJreg)
        || (opcode == cpuPkg::OpJal) || (opcode == cpuPkg::OpJmp);
    assign decoded.conditionalJump = (opcode == cpuPkg::OpBez) || (opcode == cpuPkg::OpBnez);
    assign decoded.branchOnZero    = (opcode == cpuPkg::OpBez);

    assign decoded.decodedValid = validReg;

endmodule

`default_nettype wire

// ==== rtl/registerFile.sv ====
`timescale 1ns/10ps
`default_nettype none

module registerFile (
    input  logic            Clock,
    input  logic            arstN,
    input  cpuPkg::regAddrT readAddress1,
    input  cpuPkg::regAddrT readAddress2,
    output cpuPkg::wordT    readData1,
    output cpuPkg::wordT    readData2,
    input  logic            writeEnable,
    input  cpuPkg::regAddrT writeAddress,
    input  cpuPkg::wordT    writeData
);

    // Integer bank in 0..31, float bank in 32..63
    cpuPkg::wordT registers [64];

    // Zero for address 0, otherwise a same-cycle write wins over storage
    function automatic cpuPkg::wordT readPort(input cpuPkg::regAddrT address);
        cpuPkg::wordT value;
        if (address == '0) begin
            value = '0;
        end else if (writeEnable && (writeAddress == address)) begin
            value = writeData;
        end else begin
            value = registers[address];
        end
        return value;
    endfunction

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 64; i++) begin
                registers[i] <= '0;
            end
        end else if (writeEnable && (writeAddress != '0)) begin
            registers[writeAddress] <= writeData;
        end
    end

    always_comb begin
        readData1 = readPort(readAddress1);
    end

    always_comb begin
        readData2 = readPort(readAddress2);
    end

endmodule

`default_nettype wire

// ==== rtl/operandFetch.sv ====
`timescale 1ns/10ps
`default_nettype none

module operandFetch (
    input  logic            Clock,
    input  logic            arstN,
    decodeIf.operands       decoded,
    output cpuPkg::regAddrT readAddress1,
    output cpuPkg::regAddrT readAddress2,
    input  cpuPkg::wordT    readData1,
    input  cpuPkg::wordT    readData2,
    output cpuPkg::wordT    operandA,
    output cpuPkg::wordT    operandB,
    output cpuPkg::wordT    storeData,
    output cpuPkg::wordT    immediate,
    output cpuPkg::regAddrT destination,
    output cpuPkg::funcT    functionCode,
    output logic            isLoad,
    output logic            isStore,
    output logic            isJal,
    output logic            relativeJump,
    output logic            absoluteJump,
    output logic            unconditionalJump,
    output logic            conditionalJump,
    output logic            branchOnZero,
    output logic            operandValid
);

    cpuPkg::wordT selectedB;

    assign readAddress1 = decoded.source1;
    assign readAddress2 = decoded.source2;

    assign selectedB = decoded.useImmediate ? decoded.immediate : readData2;

    // Second stage, loaded only for a decoded instruction
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            operandA          <= '0;
            operandB          <= '0;
            storeData         <= '0;
            immediate         <= '0;
            destination       <= '0;
            functionCode      <= '0;
            isLoad            <= 1'b0;
            isStore           <= 1'b0;
            isJal             <= 1'b0;
            relativeJump      <= 1'b0;
            absoluteJump      <= 1'b0;
            unconditionalJump <= 1'b0;
            conditionalJump   <= 1'b0;
            branchOnZero      <= 1'b0;
            operandValid      <= 1'b0;
        end else begin
            operandValid <= decoded.decodedValid;
            if (decoded.decodedValid) begin
                operandA          <= readData1;
                operandB          <= selectedB;
                storeData         <= readData2;
                immediate         <= decoded.immediate;
                destination       <= decoded.destination;
                functionCode      <= decoded.functionCode;
                isLoad            <= decoded.isLoad;
                isStore           <= decoded.isStore;
                isJal             <= decoded.isJal;
                relativeJump      <= decoded.relativeJump;
                absoluteJump      <= decoded.absoluteJump;
                unconditionalJump <= decoded.unconditionalJump;
                conditionalJump   <= decoded.conditionalJump;
                branchOnZero      <= decoded.branchOnZero;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/decodeStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module decodeStage (
    input  logic            Clock,
    input  logic            arstN,
    input  cpuPkg::wordT    instruction,
    input  logic            decodeStrobe,
    input  logic            writeEnable,
    input  cpuPkg::regAddrT writeAddress,
    input  cpuPkg::wordT    writeData,
    output cpuPkg::wordT    operandA,
    output cpuPkg::wordT    operandB,
    output cpuPkg::wordT    storeData,
    output cpuPkg::wordT    immediate,
    output cpuPkg::regAddrT destination,
    output cpuPkg::funcT    functionCode,
    output logic            isLoad,
    output logic            isStore,
    output logic            isJal,
    output logic            relativeJump,
    output logic            absoluteJump,
    output logic            unconditionalJump,
    output logic            conditionalJump,
    output logic            branchOnZero,
    output logic            operandValid
);

    cpuPkg::regAddrT readAddress1;
    cpuPkg::regAddrT readAddress2;
    cpuPkg::wordT    readData1;
    cpuPkg::wordT    readData2;

    decodeIf decodedBus ();

    instructionDecoder u_decoder (
        .Clock        (Clock),
        .arstN        (arstN),
        .instruction  (instruction),
        .decodeStrobe (decodeStrobe),
        .decoded      (decodedBus.decoder)
    );

    // Write port driven straight from the top level
    registerFile u_registers (
        .Clock        (Clock),
        .arstN        (arstN),
        .readAddress1 (readAddress1),
        .readAddress2 (readAddress2),
        .readData1    (readData1),
        .readData2    (readData2),
        .writeEnable  (writeEnable),
        .writeAddress (writeAddress),
        .writeData    (writeData)
    );

    operandFetch u_operands (
        .Clock             (Clock),
        .arstN             (arstN),
        .decoded           (decodedBus.operands),
        .readAddress1      (readAddress1),
        .readAddress2      (readAddress2),
        .readData1         (readData1),
        .readData2         (readData2),
        .operandA          (operandA),
        .operandB          (operandB),
        .storeData         (storeData),
        .immediate         (immediate),
        .destination       (destination),
        .functionCode      (functionCode),
        .isLoad            (isLoad),
        .isStore           (isStore),
        .isJal             (isJal),
        .relativeJump      (relativeJump),
        .absoluteJump      (absoluteJump),
        .unconditionalJump (unconditionalJump),
        .conditionalJump   (conditionalJump),
        .branchOnZero      (branchOnZero),
        .operandValid      (operandValid)
    );

endmodule

`default_nettype wire

// ==== test/tbDecodeStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module tbDecodeStage;

    // Expected results of one instruction at the operand stage
    typedef struct packed {
        cpuPkg::wordT    opA;
        cpuPkg::wordT    opB;
        cpuPkg::wordT    store;
        cpuPkg::wordT    imm;
        cpuPkg::regAddrT dest;
        cpuPkg::funcT    func;
        logic [7:0]      flags;
    } expT;

    logic            Clock = 1'b0;
    logic            arstN;
    cpuPkg::wordT    instruction;
    logic            decodeStrobe;
    logic            writeEnable;
    cpuPkg::regAddrT writeAddress;
    cpuPkg::wordT    writeData;
    cpuPkg::wordT    operandA;
    cpuPkg::wordT    operandB;
    cpuPkg::wordT    storeData;
    cpuPkg::wordT    immediate;
    cpuPkg::regAddrT destination;
    cpuPkg::funcT    functionCode;
    logic            isLoad;
    logic            isStore;
    logic            isJal;
    logic            relativeJump;
    logic            absoluteJump;
    logic            unconditionalJump;
    logic            conditionalJump;
    logic            branchOnZero;
    logic            operandValid;
    logic [7:0]      dutFlags;

    cpuPkg::wordT shadow [64];
    int           seed = 14562;
    int           errorCount = 0;
    int           testCount = 0;
    int           testStartErrors;
    string        currentTest;
    string        flagNames [8] = '{"isLoad", "isStore", "isJal", "relativeJump",
        "absoluteJump", "unconditionalJump", "conditionalJump", "branchOnZero"};

    decodeStage u_dut (
        .Clock             (Clock),
        .arstN             (arstN),
        .instruction       (instruction),
        .decodeStrobe      (decodeStrobe),
        .writeEnable       (writeEnable),
        .writeAddress      (writeAddress),
        .writeData         (writeData),
        .operandA          (operandA),
        .operandB          (operandB),
        .storeData         (storeData),
        .immediate         (immediate),
        .destination       (destination),
        .functionCode      (functionCode),
        .isLoad            (isLoad),
        .isStore           (isStore),
        .isJal             (isJal),
        .relativeJump      (relativeJump),
        .absoluteJump      (absoluteJump),
        .unconditionalJump (unconditionalJump),
        .conditionalJump   (conditionalJump),
        .branchOnZero      (branchOnZero),
        .operandValid      (operandValid)
    );

    assign dutFlags = {isLoad, isStore, isJal, relativeJump, absoluteJump,
        unconditionalJump, conditionalJump, branchOnZero};

    always #5 Clock = ~Clock;

    function automatic cpuPkg::wordT regWord(input cpuPkg::regFieldT rd,
        input cpuPkg::regFieldT rs1, input cpuPkg::regFieldT rs2, input logic [5:0] low);
        return {6'b000011, rd, rs1, rs2, 5'b00000, low};
    endfunction

    function automatic cpuPkg::wordT immWord(input cpuPkg::opcodeT op, input cpuPkg::regFieldT rd,
        input cpuPkg::regFieldT rs1, input logic [15:0] imm);
        return {op, rd, rs1, imm};
    endfunction

    function automatic cpuPkg::wordT jumpWord(input cpuPkg::opcodeT op, input logic [25:0] off);
        return {op, off};
    endfunction

    function automatic cpuPkg::wordT readShadow(input cpuPkg::regAddrT address);
        return (address == 6'd0) ? 32'd0 : shadow[address];
    endfunction

    // Reference decoder built from the encoding rules
    function automatic expT predict(input cpuPkg::wordT w);
        logic [1:0]      fmt;
        cpuPkg::opcodeT  op;
        logic [5:0]      low;
        logic            floatR;
        logic            useImm;
        cpuPkg::regAddrT src1;
        cpuPkg::regAddrT src2;
        expT             e;
        fmt = w[31:30];
        op = w[31:26];
        low = w[5:0];
        floatR = (fmt == 2'b00) && (low == 6'd2);
        useImm = (fmt == 2'b01) || w[31];
        src1 = {floatR, w[20:16]};
        if (op == cpuPkg::OpStore) begin
            src2 = {1'b0, w[25:21]};
        end else if (op == cpuPkg::OpStoreS) begin
            src2 = {1'b1, w[25:21]};
        end else begin
            src2 = {floatR, w[15:11]};
        end
        if (op == cpuPkg::OpLoadS || op == cpuPkg::OpStoreS || (floatR && low[3:0] < 4'd8)
            || (fmt == 2'b00 && (low == 6'b001110 || low == 6'b001111))) begin
            e.dest = {1'b1, w[25:21]};
        end else if (fmt == 2'b00 || w[31]) begin
            e.dest = {1'b0, w[25:21]};
        end else begin
            e.dest = 6'd0;
        end
        if (fmt == 2'b01) begin
            e.imm = {{6{w[25]}}, w[25:0]};
        end else if (op == cpuPkg::OpAddis) begin
            e.imm = {w[15:0], 16'h0000};
        end else if (w[31]) begin
            e.imm = {{16{w[15]}}, w[15:0]};
        end else begin
            e.imm = 32'd0;
        end
        if (fmt == 2'b00) begin
            e.func = low;
        end else if (op == cpuPkg::OpAddis || fmt == 2'b01 || op >= 6'b111000) begin
            e.func = 6'd0;
        end else begin
            e.func = {1'b0, w[30:26]};
        end
        // Flags ordered load, store, jal, rel, abs, uncond, cond, bez
        case (op)
            cpuPkg::OpLoad, cpuPkg::OpLoadS:   e.flags = 8'b1000_0000;
            cpuPkg::OpStore, cpuPkg::OpStoreS: e.flags = 8'b0100_0000;
            cpuPkg::OpJal:                     e.flags = 8'b0011_0100;
            cpuPkg::OpJmp:                     e.flags = 8'b0001_0100;
            cpuPkg::OpJreg:                    e.flags = 8'b0000_1100;
            cpuPkg::OpBez:                     e.flags = 8'b0001_0011;
            cpuPkg::OpBnez:                    e.flags = 8'b0001_0010;
            default:                           e.flags = 8'b0000_0000;
        endcase
        e.opA = readShadow(src1);
        e.store = readShadow(src2);
        e.opB = useImm ? e.imm : e.store;
        return e;
    endfunction

    task automatic checkWord(input string field, input cpuPkg::wordT expected,
        input cpuPkg::wordT actual);
        if (expected !== actual) begin
            $display("error %s %s: expected %h, actual %h", currentTest, field, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkRegAddr(input string field, input cpuPkg::regAddrT expected,
        input cpuPkg::regAddrT actual);
        if (expected !== actual) begin
            $display("error %s %s: expected %h, actual %h", currentTest, field, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkFunc(input string field, input cpuPkg::funcT expected,
        input cpuPkg::funcT actual);
        if (expected !== actual) begin
            $display("error %s %s: expected %h, actual %h", currentTest, field, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkFlag(input string field, input bit expected, input logic actual);
        if (actual !== expected) begin
            $display("error %s %s: expected %b, actual %b", currentTest, field, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkResult(input expT e);
        checkWord("operandA", e.opA, operandA);
        checkWord("operandB", e.opB, operandB);
        checkWord("storeData", e.store, storeData);
        checkWord("immediate", e.imm, immediate);
        checkRegAddr("destination", e.dest, destination);
        checkFunc("functionCode", e.func, functionCode);
        for (int i = 0; i < 8; i++) begin
            checkFlag(flagNames[i], e.flags[7 - i], dutFlags[7 - i]);
        end
    endtask

    task automatic startTest(input string name);
        currentTest = name;
        testStartErrors = errorCount;
        testCount++;
    endtask

    task automatic endTest();
        if (errorCount == testStartErrors) begin
            $display("%s: passed", currentTest);
        end else begin
            $display("%s: %0d errors", currentTest, errorCount - testStartErrors);
        end
    endtask

    task automatic writeReg(input cpuPkg::regAddrT address, input cpuPkg::wordT data);
        @(posedge Clock);
        writeEnable <= 1'b1;
        writeAddress <= address;
        writeData <= data;
        @(posedge Clock);
        writeEnable <= 1'b0;
        if (address != 6'd0) begin
            shadow[address] = data;
        end
    endtask

    // Samples on falling edges, away from the DUT's updates
    task automatic waitValid();
        int cycles;
        bit seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < 20) begin
            @(negedge Clock);
            seen = operandValid;
            cycles++;
        end
        if (!seen) begin
            $display("%s: operandValid never went high within 20 cycles", currentTest);
            errorCount++;
        end
    endtask

    task automatic runInstruction(input cpuPkg::wordT w);
        expT e;
        e = predict(w);
        @(posedge Clock);
        instruction <= w;
        decodeStrobe <= 1'b1;
        @(posedge Clock);
        decodeStrobe <= 1'b0;
        waitValid();
        checkResult(e);
        @(negedge Clock);
        checkFlag("operandValid pulse end", 1'b0, operandValid);
    endtask

    task automatic testReset();
        expT zero;
        startTest("reset");
        zero = '0;
        // Park a jump-and-link in the operand stage, then reset over it
        @(posedge Clock);
        instruction <= immWord(cpuPkg::OpJal, 5'd31, 5'd1, 16'h0100);
        decodeStrobe <= 1'b1;
        @(posedge Clock);
        decodeStrobe <= 1'b0;
        waitValid();
        @(posedge Clock);
        arstN <= 1'b0;
        repeat (5) @(posedge Clock);
        arstN <= 1'b1;
        @(negedge Clock);
        checkFlag("operandValid", 1'b0, operandValid);
        checkResult(zero);
        endTest();
    endtask

    task automatic testRegisterFormat();
        startTest("registerFormat");
        runInstruction(regWord(5'd7, 5'd3, 5'd4, 6'h20));
        runInstruction(regWord(5'd8, 5'd5, 5'd6, cpuPkg::CategoryFloat));
        runInstruction(regWord(5'd9, 5'd10, 5'd11, cpuPkg::FuncIToF));
        runInstruction(regWord(5'd12, 5'd13, 5'd14, cpuPkg::FuncUIToF));
        runInstruction(regWord(5'd15, 5'd16, 5'd17, 6'b001000));
        runInstruction(regWord(5'd18, 5'd19, 5'd20, 6'b111010));
        endTest();
    endtask

    task automatic testImmediate();
        startTest("immediate");
        runInstruction(immWord(6'b100011, 5'd2, 5'd3, 16'h8001));
        runInstruction(immWord(6'b101000, 5'd4, 5'd5, 16'h1234));
        runInstruction(immWord(cpuPkg::OpAddis, 5'd6, 5'd7, 16'hbeef));
        runInstruction(jumpWord(cpuPkg::OpJmp, 26'h2000001));
        runInstruction(jumpWord(6'b010101, 26'h0000123));
        endTest();
    endtask

    task automatic testLoadStore();
        startTest("loadStore");
        runInstruction(immWord(cpuPkg::OpLoad, 5'd21, 5'd22, 16'h0010));
        runInstruction(immWord(cpuPkg::OpLoadS, 5'd23, 5'd24, 16'hfff0));
        runInstruction(immWord(cpuPkg::OpStore, 5'd25, 5'd26, 16'h0004));
        runInstruction(immWord(cpuPkg::OpStoreS, 5'd27, 5'd28, 16'h8000));
        endTest();
    endtask

    task automatic testJumps();
        startTest("jumps");
        runInstruction(immWord(cpuPkg::OpJreg, 5'd0, 5'd29, 16'h0000));
        runInstruction(immWord(cpuPkg::OpBez, 5'd0, 5'd30, 16'hff00));
        runInstruction(immWord(cpuPkg::OpBnez, 5'd0, 5'd31, 16'h0040));
        runInstruction(immWord(cpuPkg::OpJal, 5'd31, 5'd1, 16'h0100));
        runInstruction(jumpWord(cpuPkg::OpJmp, 26'h0000200));
        endTest();
    endtask

    task automatic testForwardAndOrder();
        cpuPkg::wordT data;
        cpuPkg::wordT w1;
        cpuPkg::wordT w2;
        expT          e1;
        expT          e2;
        startTest("forwardAndOrder");
        // Write lands in the same cycle the operand stage reads it
        data = $random(seed);
        shadow[9] = data;
        e1 = predict(regWord(5'd1, 5'd9, 5'd10, 6'h20));
        @(posedge Clock);
        instruction <= regWord(5'd1, 5'd9, 5'd10, 6'h20);
        decodeStrobe <= 1'b1;
        @(posedge Clock);
        decodeStrobe <= 1'b0;
        writeEnable <= 1'b1;
        writeAddress <= 6'd9;
        writeData <= data;
        @(posedge Clock);
        writeEnable <= 1'b0;
        waitValid();
        checkResult(e1);
        writeReg(6'd0, $random(seed));
        runInstruction(regWord(5'd2, 5'd0, 5'd0, 6'h21));
        w1 = immWord(cpuPkg::OpLoad, 5'd3, 5'd4, 16'h0008);
        w2 = regWord(5'd5, 5'd6, 5'd7, cpuPkg::CategoryFloat);
        e1 = predict(w1);
        e2 = predict(w2);
        @(posedge Clock);
        instruction <= w1;
        decodeStrobe <= 1'b1;
        @(posedge Clock);
        instruction <= w2;
        @(posedge Clock);
        decodeStrobe <= 1'b0;
        waitValid();
        checkResult(e1);
        @(negedge Clock);
        checkFlag("second operandValid", 1'b1, operandValid);
        checkResult(e2);
        @(negedge Clock);
        checkFlag("operandValid after pair", 1'b0, operandValid);
        endTest();
    endtask

    initial begin
        instruction <= '0;
        decodeStrobe <= 1'b0;
        writeEnable <= 1'b0;
        writeAddress <= '0;
        writeData <= '0;
        arstN <= 1'b0;
        for (int i = 0; i < 64; i++) begin
            shadow[i] = '0;
        end
        repeat (5) @(posedge Clock);
        arstN <= 1'b1;
        testReset();
        for (int i = 1; i < 64; i++) begin
            writeReg(6'(i), $random(seed));
        end
        testRegisterFormat();
        testImmediate();
        testLoadStore();
        testJumps();
        testForwardAndOrder();
        $display("tests run %0d, errors %0d", testCount, errorCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
rtl/cpuPkg.sv
rtl/decodeIf.sv
rtl/instructionDecoder.sv
rtl/registerFile.sv
rtl/operandFetch.sv
rtl/decodeStage.sv
test/tbDecodeStage.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps -f list.f \
    --top-module tbDecodeStage -o simDecodeStage

output=$(./obj_dir/simDecodeStage)
echo "$output"

if echo "$output" | grep -q "Done: no errors"; then
    exit 0
fi
exit 1
